//--- src/ifu_pkg.sv
package ifu_pkg;

    // instruction word as fetched from the icache
    typedef logic [31:0] inst_t;

    // byte address of an instruction
    typedef logic [31:0] pc_t;

    // queue slot index, wraps modulo 16 on its own
    typedef logic [3:0] ptr_t;

    // occupancy 0..16, one bit wider than the index
    typedef logic [4:0] count_t;

    // entries removed per cycle, 0..2
    typedef logic [1:0] pop_t;

    // storage depth of the issue queue
    localparam int QUEUE_DEPTH = 16;

    // full is raised here so a dual write still has room
    // the extra headroom covers the fetch stall latency
    localparam int FULL_LEVEL = 14;

endpackage

//--- src/inst_queue.sv
`timescale 1ns/1ps

module inst_queue import ifu_pkg::*; (
    input  logic   clk,
    input  logic   fifo_rst,
    input  logic   redirect,

    // fetch side, two instructions per cycle at most
    input  logic   write_en1,
    input  logic   write_en2,
    input  inst_t  write_inst1,
    input  inst_t  write_inst2,
    input  pc_t    write_pc1,
    input  pc_t    write_pc2,

    // entries consumed by decode this cycle
    input  pop_t   pop,

    // the two oldest entries
    output inst_t  head_inst0,
    output inst_t  head_inst1,
    output pc_t    head_pc0,
    output pc_t    head_pc1,

    output count_t count,
    output logic   empty,
    output logic   almost_empty,
    output logic   full
);

    // payload storage, instruction and pc kept apart
    inst_t inst_mem [QUEUE_DEPTH];
    pc_t   pc_mem [QUEUE_DEPTH];

    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    ptr_t  wr_ptr_p1;
    ptr_t  rd_ptr_p1;

    // accepted writes after back-pressure and flush
    logic   accept1;
    logic   accept2;
    count_t wr_num;
    count_t count_next;

    assign wr_ptr_p1 = wr_ptr + ptr_t'(1);
    assign rd_ptr_p1 = rd_ptr + ptr_t'(1);

    // occupancy flags straight from the registered count
    assign empty        = (count == count_t'(0));
    assign almost_empty = (count == count_t'(1));
    assign full         = (count >= count_t'(FULL_LEVEL));

    // fetch stalls on full, so anything offered then is dropped
    // second port only counts together with the first
    always_comb begin
        accept1 = write_en1 && !full && !redirect;
        accept2 = write_en2 && write_en1 && !full && !redirect;
    end

    always_comb begin
        wr_num     = count_t'(accept1) + count_t'(accept2);
        count_next = count + wr_num - count_t'(pop);
    end

    // head reads are combinational, zero latency to decode
    assign head_inst0 = inst_mem[rd_ptr];
    assign head_pc0   = pc_mem[rd_ptr];
    assign head_inst1 = inst_mem[rd_ptr_p1];
    assign head_pc1   = pc_mem[rd_ptr_p1];

    // storage writes, port 1 at wr_ptr and port 2 right after it
    always_ff @(posedge clk) begin
        if (accept1) begin
            inst_mem[wr_ptr] <= write_inst1;
            pc_mem[wr_ptr]   <= write_pc1;
        end
        if (accept2) begin
            inst_mem[wr_ptr_p1] <= write_inst2;
            pc_mem[wr_ptr_p1]   <= write_pc2;
        end
    end

    // write pointer
    always_ff @(posedge clk) begin
        if (fifo_rst || redirect) begin
            wr_ptr <= '0;
        end else if (accept2) begin
            wr_ptr <= wr_ptr + ptr_t'(2);
        end else if (accept1) begin
            wr_ptr <= wr_ptr_p1;
        end
    end

    // read pointer moves by the selector's pop
    // redirect wins over any pop in the same cycle
    always_ff @(posedge clk) begin
        if (fifo_rst || redirect) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr + ptr_t'(pop);
        end
    end

    // occupancy, writes and pops in one step
    always_ff @(posedge clk) begin
        if (fifo_rst || redirect) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

//--- src/delayslot_tracker.sv
`timescale 1ns/1ps

module delayslot_tracker import ifu_pkg::*; (
    input  logic  clk,
    input  logic  fifo_rst,
    input  logic  redirect,
    input  logic  delay_keep,

    // issue status from decode
    input  logic  read_en1,
    input  logic  read_en2,
    input  logic  master_is_branch,

    // current master slot, looped back from the selector
    input  logic  master_valid,
    input  inst_t master_inst,
    input  pc_t   master_pc,

    // captured delay slot instruction
    output logic  hold_valid,
    output inst_t hold_inst,
    output pc_t   hold_pc,

    output logic  master_in_delayslot
);

    // capture condition for the held instruction
    logic capture;

    // a branch issued alone leaves its slot as the next master
    // branch and slot issued together clear the flag
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            master_in_delayslot <= 1'b0;
        end else if (read_en1) begin
            master_in_delayslot <= master_is_branch && !read_en2;
        end
    end

    // keep the pending master through the flush
    // only when decode has not taken it yet
    assign capture = redirect && delay_keep && !read_en1 && master_valid;

    // hold valid bit
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            hold_valid <= 1'b0;
        end else if (capture) begin
            hold_valid <= 1'b1;
        end else if (read_en1) begin
            // released once decode issues it
            hold_valid <= 1'b0;
        end
    end

    // held payload, only meaningful while hold_valid
    always_ff @(posedge clk) begin
        if (capture) begin
            hold_inst <= master_inst;
            hold_pc   <= master_pc;
        end
    end

endmodule

//--- src/issue_select.sv
`timescale 1ns/1ps

module issue_select import ifu_pkg::*; (
    // held delay slot instruction
    input  logic   hold_valid,
    input  inst_t  hold_inst,
    input  pc_t    hold_pc,

    // queue heads and occupancy
    input  inst_t  head_inst0,
    input  pc_t    head_pc0,
    input  inst_t  head_inst1,
    input  pc_t    head_pc1,
    input  count_t count,

    // issue status from decode
    input  logic   read_en1,
    input  logic   read_en2,

    // master slot
    output logic   master_valid,
    output inst_t  master_inst,
    output pc_t    master_pc,

    // slave slot
    output logic   slave_valid,
    output inst_t  slave_inst,
    output pc_t    slave_pc,

    output pop_t   pop
);

    // issue only counts for slots that hold something
    logic take1;
    logic take2;

    always_comb begin
        master_valid = 1'b0;
        master_inst  = '0;
        master_pc    = '0;
        slave_valid  = 1'b0;
        slave_inst   = '0;
        slave_pc     = '0;
        if (hold_valid) begin
            // held instruction goes out alone, queue waits behind it
            master_valid = 1'b1;
            master_inst  = hold_inst;
            master_pc    = hold_pc;
        end else begin
            if (count >= count_t'(1)) begin
                master_valid = 1'b1;
                master_inst  = head_inst0;
                master_pc    = head_pc0;
            end
            if (count >= count_t'(2)) begin
                slave_valid = 1'b1;
                slave_inst  = head_inst1;
                slave_pc    = head_pc1;
            end
        end
    end

    // no pop while the hold register feeds the master slot
    assign take1 = read_en1 && master_valid && !hold_valid;
    assign take2 = read_en2 && slave_valid;

    assign pop = pop_t'(take1) + pop_t'(take2);

endmodule

//--- src/ifu_issue_buffer.sv
`timescale 1ns/1ps

module ifu_issue_buffer import ifu_pkg::*; (
    input  logic  clk,
    input  logic  fifo_rst,

    // fetch side
    input  logic  write_en1,
    input  logic  write_en2,
    input  inst_t write_inst1,
    input  inst_t write_inst2,
    input  pc_t   write_pc1,
    input  pc_t   write_pc2,

    // decode side
    input  logic  read_en1,
    input  logic  read_en2,

    // branch and flush control
    input  logic  master_is_branch,
    input  logic  redirect,
    input  logic  delay_keep,

    output logic  master_valid,
    output inst_t master_inst,
    output pc_t   master_pc,
    output logic  slave_valid,
    output inst_t slave_inst,
    output pc_t   slave_pc,

    output logic  master_in_delayslot,
    output logic  empty,
    output logic  almost_empty,
    output logic  full
);

    // queue to selector
    inst_t  head_inst0;
    pc_t    head_pc0;
    inst_t  head_inst1;
    pc_t    head_pc1;
    count_t count;

    // tracker to selector
    logic   hold_valid;
    inst_t  hold_inst;
    pc_t    hold_pc;

    // selector back to queue
    pop_t   pop;

    inst_queue u_queue (
        .clk          (clk),
        .fifo_rst     (fifo_rst),
        .redirect     (redirect),
        .write_en1    (write_en1),
        .write_en2    (write_en2),
        .write_inst1  (write_inst1),
        .write_inst2  (write_inst2),
        .write_pc1    (write_pc1),
        .write_pc2    (write_pc2),
        .pop          (pop),
        .head_inst0   (head_inst0),
        .head_inst1   (head_inst1),
        .head_pc0     (head_pc0),
        .head_pc1     (head_pc1),
        .count        (count),
        .empty        (empty),
        .almost_empty (almost_empty),
        .full         (full)
    );

    // tracker sees the master slot as decode sees it
    delayslot_tracker u_tracker (
        .clk                 (clk),
        .fifo_rst            (fifo_rst),
        .redirect            (redirect),
        .delay_keep          (delay_keep),
        .read_en1            (read_en1),
        .read_en2            (read_en2),
        .master_is_branch    (master_is_branch),
        .master_valid        (master_valid),
        .master_inst         (master_inst),
        .master_pc           (master_pc),
        .hold_valid          (hold_valid),
        .hold_inst           (hold_inst),
        .hold_pc             (hold_pc),
        .master_in_delayslot (master_in_delayslot)
    );

    issue_select u_select (
        .hold_valid   (hold_valid),
        .hold_inst    (hold_inst),
        .hold_pc      (hold_pc),
        .head_inst0   (head_inst0),
        .head_pc0     (head_pc0),
        .head_inst1   (head_inst1),
        .head_pc1     (head_pc1),
        .count        (count),
        .read_en1     (read_en1),
        .read_en2     (read_en2),
        .master_valid (master_valid),
        .master_inst  (master_inst),
        .master_pc    (master_pc),
        .slave_valid  (slave_valid),
        .slave_inst   (slave_inst),
        .slave_pc     (slave_pc),
        .pop          (pop)
    );

endmodule

//--- dv/tb_ifu_issue_buffer.sv
`timescale 1ns/1ps

module tb_ifu_issue_buffer import ifu_pkg::*; ();

    localparam pc_t PC_BASE = 32'h0040_0000;

    logic  clk;
    logic  fifo_rst;
    logic  write_en1;
    logic  write_en2;
    inst_t write_inst1;
    inst_t write_inst2;
    pc_t   write_pc1;
    pc_t   write_pc2;
    logic  read_en1;
    logic  read_en2;
    logic  master_is_branch;
    logic  redirect;
    logic  delay_keep;
    logic  master_valid;
    inst_t master_inst;
    pc_t   master_pc;
    logic  slave_valid;
    inst_t slave_inst;
    pc_t   slave_pc;
    logic  master_in_delayslot;
    logic  empty;
    logic  almost_empty;
    logic  full;

    // reference queue and side state
    inst_t mq_inst[$];
    pc_t   mq_pc[$];
    logic  m_hold;
    inst_t m_hold_inst;
    pc_t   m_hold_pc;
    logic  m_flag;
    logic  capture;
    logic  take1;
    logic  take2;

    // expected outputs for the current cycle
    int    exp_count;
    logic  exp_mv;
    inst_t exp_minst;
    pc_t   exp_mpc;
    logic  exp_sv;
    inst_t exp_sinst;
    pc_t   exp_spc;

    logic [31:0] seq;
    int err_count;
    int timeout_count;
    int n;

    ifu_issue_buffer u_dut (.*);

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
        err_count++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        timeout_count++;
    endtask

    task automatic refresh_expected();
        exp_count = mq_inst.size();
        exp_mv    = m_hold || (exp_count >= 1);
        exp_minst = m_hold ? m_hold_inst : ((exp_count >= 1) ? mq_inst[0] : '0);
        exp_mpc   = m_hold ? m_hold_pc : ((exp_count >= 1) ? mq_pc[0] : '0);
        exp_sv    = !m_hold && (exp_count >= 2);
        exp_sinst = exp_sv ? mq_inst[1] : '0;
        exp_spc   = exp_sv ? mq_pc[1] : '0;
    endtask

    // model steps on the same edge as the DUT
    always @(posedge clk) begin
        if (fifo_rst) begin
            mq_inst.delete();
            mq_pc.delete();
            m_hold = 1'b0;
            m_flag = 1'b0;
        end else begin
            capture = redirect && delay_keep && !read_en1 && exp_mv;
            take1   = read_en1 && exp_mv && !m_hold;
            take2   = read_en2 && exp_sv;
            if (read_en1)
                m_flag = master_is_branch && !read_en2;
            if (capture) begin
                m_hold      = 1'b1;
                m_hold_inst = exp_minst;
                m_hold_pc   = exp_mpc;
            end else if (read_en1) begin
                m_hold = 1'b0;
            end
            if (redirect) begin
                mq_inst.delete();
                mq_pc.delete();
            end else begin
                repeat (int'(take1) + int'(take2)) begin
                    void'(mq_inst.pop_front());
                    void'(mq_pc.pop_front());
                end
                // writes offered while full are dropped
                if (write_en1 && exp_count < FULL_LEVEL) begin
                    mq_inst.push_back(write_inst1);
                    mq_pc.push_back(write_pc1);
                    if (write_en2) begin
                        mq_inst.push_back(write_inst2);
                        mq_pc.push_back(write_pc2);
                    end
                end
            end
        end
        refresh_expected();
    end

    property same(logic [31:0] act, logic [31:0] exp);
        @(posedge clk) disable iff (fifo_rst) act == exp;
    endproperty

    a_master_valid: assert property (same(master_valid, exp_mv))
        else report_mismatch("master_valid", $sampled(exp_mv), $sampled(master_valid));
    a_master_inst: assert property (same(master_inst, exp_minst))
        else report_mismatch("master_inst", $sampled(exp_minst), $sampled(master_inst));
    a_master_pc: assert property (same(master_pc, exp_mpc))
        else report_mismatch("master_pc", $sampled(exp_mpc), $sampled(master_pc));
    a_slave_valid: assert property (same(slave_valid, exp_sv))
        else report_mismatch("slave_valid", $sampled(exp_sv), $sampled(slave_valid));
    a_slave_inst: assert property (same(slave_inst, exp_sinst))
        else report_mismatch("slave_inst", $sampled(exp_sinst), $sampled(slave_inst));
    a_slave_pc: assert property (same(slave_pc, exp_spc))
        else report_mismatch("slave_pc", $sampled(exp_spc), $sampled(slave_pc));
    a_delayslot: assert property (same(master_in_delayslot, m_flag))
        else report_mismatch("delayslot", $sampled(m_flag), $sampled(master_in_delayslot));
    a_empty: assert property (same(empty, exp_count == 0))
        else report_mismatch("empty", $sampled(exp_count == 0), $sampled(empty));
    a_almost_empty: assert property (same(almost_empty, exp_count == 1))
        else report_mismatch("almost_empty", $sampled(exp_count == 1), $sampled(almost_empty));
    a_full: assert property (same(full, exp_count >= FULL_LEVEL))
        else report_mismatch("full", $sampled(exp_count >= FULL_LEVEL), $sampled(full));
    a_slave_low: assert property (@(posedge clk) disable iff (fifo_rst)
                                  (exp_count < 2) |-> !slave_valid)
        else report_mismatch("slave_low", 32'h0, $sampled(slave_valid));

    // one cycle of random fetch and decode activity
    task automatic drive_cycle(input bit allow_write, input bit allow_read,
                               input bit allow_redirect);
        @(negedge clk);
        write_en1        = allow_write && !full && ($urandom % 4 != 0);
        write_en2        = write_en1 && ($urandom % 2 == 1);
        write_inst1      = seq;
        write_pc1        = PC_BASE + seq * 4;
        write_inst2      = seq + 1;
        write_pc2        = PC_BASE + (seq + 1) * 4;
        seq              = seq + 32'(write_en1) + 32'(write_en2);
        read_en1         = allow_read && ($urandom % 4 != 0);
        read_en2         = read_en1 && ($urandom % 2 == 1);
        master_is_branch = ($urandom % 4 == 0);
        redirect         = allow_redirect && ($urandom % 30 == 0);
        delay_keep       = ($urandom % 2 == 1);
    endtask

    initial begin
        void'($urandom(32'h23f2));
        clk = 1'b0;
        fifo_rst = 1'b1;
        {write_en1, write_en2, read_en1, read_en2} = '0;
        {master_is_branch, redirect, delay_keep} = '0;
        {write_inst1, write_inst2, write_pc1, write_pc2} = '0;
        seq = 32'h1;
        err_count = 0;
        timeout_count = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        fifo_rst = 1'b0;

        // mixed traffic with occasional flushes
        repeat (300) drive_cycle(1, 1, 1);

        // back-pressure, fill with no reads
        n = 0;
        while (!full && n < 40) begin
            drive_cycle(1, 0, 0);
            n++;
        end
        if (!full)
            report_timeout("queue never raised full");
        repeat (4) drive_cycle(1, 0, 0);

        // drain everything in order
        n = 0;
        while (!(empty && !master_valid) && n < 80) begin
            drive_cycle(0, 1, 0);
            n++;
        end
        if (!(empty && !master_valid))
            report_timeout("queue did not drain");

        // refill, then flush with delay_keep while master waits
        n = 0;
        while (!master_valid && n < 20) begin
            drive_cycle(1, 0, 0);
            n++;
        end
        if (!master_valid)
            report_timeout("master slot never became valid");
        @(negedge clk);
        {write_en1, write_en2, read_en1, read_en2} = '0;
        redirect   = 1'b1;
        delay_keep = 1'b1;
        // new writes queue up behind the held instruction
        repeat (4) drive_cycle(1, 0, 0);
        repeat (300) drive_cycle(1, 1, 1);

        @(negedge clk);
        {write_en1, write_en2, read_en1, read_en2, redirect} = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("run done: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- ifu_issue_buffer.f
src/ifu_pkg.sv
src/inst_queue.sv
src/delayslot_tracker.sv
src/issue_select.sv
src/ifu_issue_buffer.sv
dv/tb_ifu_issue_buffer.sv

//--- Bender.yml
package:
  name: ifu_issue_buffer

sources:
  - src/ifu_pkg.sv
  - src/inst_queue.sv
  - src/delayslot_tracker.sv
  - src/issue_select.sv
  - src/ifu_issue_buffer.sv
  - target: test
    files:
      - dv/tb_ifu_issue_buffer.sv
